//--- source/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    // data and address word.
    typedef logic [31:0] word_t;

    // architectural register index.
    typedef logic [4:0] reg_addr_t;

    // major opcode field, instr[6:0].
    typedef logic [6:0] opcode_t;

    // the three major opcodes the core executes.
    localparam opcode_t OPC_OP     = 7'b0110011;
    localparam opcode_t OPC_OP_IMM = 7'b0010011;
    localparam opcode_t OPC_LUI    = 7'b0110111;

    // alu operation select.
    // ALU_PASS_B forwards the second operand, used by lui.
    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_AND    = 4'd2,
        ALU_OR     = 4'd3,
        ALU_XOR    = 4'd4,
        ALU_SLL    = 4'd5,
        ALU_SRL    = 4'd6,
        ALU_SRA    = 4'd7,
        ALU_SLT    = 4'd8,
        ALU_SLTU   = 4'd9,
        ALU_PASS_B = 4'd10
    } alu_op_e;

endpackage

`default_nettype wire

//--- source/fetch_stage.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_stage #(
    parameter cpu_pkg::word_t RESET_PC = '0
) (
    input  wire                  clk,
    input  wire                  rstn,
    input  wire                  instr_valid,
    input  wire cpu_pkg::word_t  instr,
    output logic                 f_valid,
    output cpu_pkg::word_t       f_pc,
    output cpu_pkg::word_t       f_instr
);

    // pc of the next accepted instruction.
    cpu_pkg::word_t pc;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            pc      <= RESET_PC;
            f_valid <= 1'b0;
        end else begin
            f_valid <= instr_valid;
            // only accepted instructions move the pc.
            if (instr_valid) begin
                pc <= pc + 32'd4;
            end
        end
    end

    // payload of the fetch register.
    always_ff @(posedge clk) begin
        if (instr_valid) begin
            f_pc    <= pc;
            f_instr <= instr;
        end
    end

endmodule

`default_nettype wire

//--- source/decoder.sv
`timescale 1ns/1ps
`default_nettype none

module decoder (
    input  wire cpu_pkg::word_t  f_instr,
    output cpu_pkg::reg_addr_t   rs1,
    output cpu_pkg::reg_addr_t   rs2,
    output cpu_pkg::reg_addr_t   rd,
    output cpu_pkg::word_t       imm,
    output logic                 use_imm,
    output cpu_pkg::alu_op_e     alu_op,
    output logic                 writes_rd
);

    cpu_pkg::opcode_t opcode;
    logic [2:0]       funct3;
    logic             funct7_alt;
    logic             supported;

    // funct3 map shared by OP and OP-IMM.
    // sub only exists in the register form.
    function automatic cpu_pkg::alu_op_e alu_sel(input logic [2:0] f3,
                                                 input logic alt,
                                                 input logic reg_form);
        cpu_pkg::alu_op_e op;
        case (f3)
            3'b000:  op = (alt && reg_form) ? cpu_pkg::ALU_SUB : cpu_pkg::ALU_ADD;
            3'b001:  op = cpu_pkg::ALU_SLL;
            3'b010:  op = cpu_pkg::ALU_SLT;
            3'b011:  op = cpu_pkg::ALU_SLTU;
            3'b100:  op = cpu_pkg::ALU_XOR;
            3'b101:  op = alt ? cpu_pkg::ALU_SRA : cpu_pkg::ALU_SRL;
            3'b110:  op = cpu_pkg::ALU_OR;
            default: op = cpu_pkg::ALU_AND;
        endcase
        return op;
    endfunction

    assign opcode     = f_instr[6:0];
    assign funct3     = f_instr[14:12];
    // bit 30 separates sub from add and sra from srl.
    assign funct7_alt = f_instr[30];

    assign rs1 = f_instr[19:15];
    assign rs2 = f_instr[24:20];
    assign rd  = f_instr[11:7];

    always_comb begin
        imm       = '0;
        use_imm   = 1'b0;
        alu_op    = cpu_pkg::ALU_ADD;
        supported = 1'b0;
        case (opcode)
            cpu_pkg::OPC_OP: begin
                alu_op    = alu_sel(funct3, funct7_alt, 1'b1);
                supported = 1'b1;
            end
            cpu_pkg::OPC_OP_IMM: begin
                // i-type immediate, sign extended.
                // shift forms keep funct7 in the upper bits, the alu ignores them.
                imm       = {{20{f_instr[31]}}, f_instr[31:20]};
                use_imm   = 1'b1;
                alu_op    = alu_sel(funct3, funct7_alt, 1'b0);
                supported = 1'b1;
            end
            cpu_pkg::OPC_LUI: begin
                imm       = {f_instr[31:12], 12'b0};
                use_imm   = 1'b1;
                alu_op    = cpu_pkg::ALU_PASS_B;
                supported = 1'b1;
            end
            default: begin
                // anything else retires as a no-op.
                supported = 1'b0;
            end
        endcase
    end

    assign writes_rd = supported && (rd != '0);

endmodule

`default_nettype wire

//--- source/register_file.sv
`timescale 1ns/1ps
`default_nettype none

module register_file (
    input  wire                      clk,
    input  wire                      rstn,
    input  wire cpu_pkg::reg_addr_t  rs1,
    input  wire cpu_pkg::reg_addr_t  rs2,
    output cpu_pkg::word_t           rs1_data,
    output cpu_pkg::word_t           rs2_data,
    input  wire                      wr_en,
    input  wire cpu_pkg::reg_addr_t  wr_addr,
    input  wire cpu_pkg::word_t      wr_data
);

    // x1..x31, x0 has no storage.
    cpu_pkg::word_t regs [1:31];

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (wr_addr != '0)) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // asynchronous read, x0 reads zero.
    assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

    // the decoder never lets an rd of x0 reach the write port.
    a_no_x0_write: assert property (
        @(posedge clk) disable iff (!rstn) wr_en |-> (wr_addr != '0)
    ) else $error("register write to x0");

endmodule

`default_nettype wire

//--- source/dispatch_stage.sv
`timescale 1ns/1ps
`default_nettype none

module dispatch_stage (
    input  wire                      clk,
    input  wire                      rstn,
    input  wire                      f_valid,
    input  wire cpu_pkg::word_t      f_pc,
    input  wire cpu_pkg::reg_addr_t  rs1,
    input  wire cpu_pkg::reg_addr_t  rs2,
    input  wire cpu_pkg::reg_addr_t  rd,
    input  wire cpu_pkg::word_t      imm,
    input  wire                      use_imm,
    input  wire cpu_pkg::alu_op_e    alu_op,
    input  wire                      writes_rd,
    input  wire cpu_pkg::word_t      rs1_data,
    input  wire cpu_pkg::word_t      rs2_data,
    input  wire cpu_pkg::word_t      alu_result,
    input  wire                      retire_valid,
    input  wire                      retire_write,
    input  wire cpu_pkg::reg_addr_t  retire_rd,
    input  wire cpu_pkg::word_t      retire_data,
    output logic                     d_valid,
    output cpu_pkg::word_t           d_pc,
    output cpu_pkg::reg_addr_t       d_rd,
    output logic                     d_write,
    output cpu_pkg::alu_op_e         d_alu_op,
    output cpu_pkg::word_t           d_a,
    output cpu_pkg::word_t           d_b
);

    cpu_pkg::word_t op_a;
    cpu_pkg::word_t op_b;

    // youngest producer wins: alu, then completion register, then regfile.
    function automatic cpu_pkg::word_t fwd_operand(input cpu_pkg::reg_addr_t src,
                                                   input cpu_pkg::word_t rf_data);
        cpu_pkg::word_t value;
        if (src == '0) begin
            value = '0;
        end else if (d_valid && d_write && (d_rd == src)) begin
            value = alu_result;
        end else if (retire_valid && retire_write && (retire_rd == src)) begin
            value = retire_data;
        end else begin
            value = rf_data;
        end
        return value;
    endfunction

    always_comb begin
        op_a = fwd_operand(rs1, rs1_data);
        op_b = use_imm ? imm : fwd_operand(rs2, rs2_data);
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            d_valid <= 1'b0;
            d_write <= 1'b0;
        end else begin
            d_valid <= f_valid;
            d_write <= f_valid && writes_rd;
        end
    end

    always_ff @(posedge clk) begin
        d_pc     <= f_pc;
        d_rd     <= rd;
        d_alu_op <= alu_op;
        d_a      <= op_a;
        d_b      <= op_b;
    end

endmodule

`default_nettype wire

//--- source/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  wire cpu_pkg::word_t    d_a,
    input  wire cpu_pkg::word_t    d_b,
    input  wire cpu_pkg::alu_op_e  d_alu_op,
    output cpu_pkg::word_t         alu_result
);

    // shifts use the low five bits only.
    logic [4:0] shamt;

    assign shamt = d_b[4:0];

    always_comb begin
        case (d_alu_op)
            cpu_pkg::ALU_ADD:    alu_result = d_a + d_b;
            cpu_pkg::ALU_SUB:    alu_result = d_a - d_b;
            cpu_pkg::ALU_AND:    alu_result = d_a & d_b;
            cpu_pkg::ALU_OR:     alu_result = d_a | d_b;
            cpu_pkg::ALU_XOR:    alu_result = d_a ^ d_b;
            cpu_pkg::ALU_SLL:    alu_result = d_a << shamt;
            cpu_pkg::ALU_SRL:    alu_result = d_a >> shamt;
            cpu_pkg::ALU_SRA:    alu_result = $unsigned($signed(d_a) >>> shamt);
            cpu_pkg::ALU_SLT: begin
                alu_result = {31'b0, $signed(d_a) < $signed(d_b)};
            end
            cpu_pkg::ALU_SLTU: begin
                alu_result = {31'b0, d_a < d_b};
            end
            cpu_pkg::ALU_PASS_B: alu_result = d_b;
            // spare encodings.
            default:             alu_result = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- source/complete_stage.sv
`timescale 1ns/1ps
`default_nettype none

module complete_stage (
    input  wire                      clk,
    input  wire                      rstn,
    input  wire                      d_valid,
    input  wire cpu_pkg::word_t      d_pc,
    input  wire cpu_pkg::reg_addr_t  d_rd,
    input  wire                      d_write,
    input  wire cpu_pkg::word_t      alu_result,
    output logic                     retire_valid,
    output cpu_pkg::word_t           retire_pc,
    output logic                     retire_write,
    output cpu_pkg::reg_addr_t       retire_rd,
    output cpu_pkg::word_t           retire_data
);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            retire_valid <= 1'b0;
            retire_write <= 1'b0;
        end else begin
            retire_valid <= d_valid;
            retire_write <= d_write;
        end
    end

    // doubles as the register file write port and the forward source.
    always_ff @(posedge clk) begin
        retire_pc   <= d_pc;
        retire_rd   <= d_rd;
        retire_data <= alu_result;
    end

    // dispatch only raises d_write for a valid instruction.
    a_write_needs_valid: assert property (
        @(posedge clk) disable iff (!rstn) retire_write |-> retire_valid
    ) else $error("retire_write without retire_valid");

endmodule

`default_nettype wire

//--- source/cpu_core.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_core #(
    parameter cpu_pkg::word_t RESET_PC = '0
) (
    input  wire                  clk,
    input  wire                  rstn,
    input  wire                  instr_valid,
    input  wire cpu_pkg::word_t  instr,
    output logic                 retire_valid,
    output cpu_pkg::word_t       retire_pc,
    output logic                 retire_write,
    output cpu_pkg::reg_addr_t   retire_rd,
    output cpu_pkg::word_t       retire_data
);

    // fetch register.
    logic               f_valid;
    cpu_pkg::word_t     f_pc;
    cpu_pkg::word_t     f_instr;

    // decode outputs.
    cpu_pkg::reg_addr_t rs1;
    cpu_pkg::reg_addr_t rs2;
    cpu_pkg::reg_addr_t rd;
    cpu_pkg::word_t     imm;
    logic               use_imm;
    cpu_pkg::alu_op_e   alu_op;
    logic               writes_rd;
    cpu_pkg::word_t     rs1_data;
    cpu_pkg::word_t     rs2_data;

    // dispatch register and alu.
    logic               d_valid;
    cpu_pkg::word_t     d_pc;
    cpu_pkg::reg_addr_t d_rd;
    logic               d_write;
    cpu_pkg::alu_op_e   d_alu_op;
    cpu_pkg::word_t     d_a;
    cpu_pkg::word_t     d_b;
    cpu_pkg::word_t     alu_result;

    fetch_stage #(
        .RESET_PC (RESET_PC)
    ) fetch_stage_i (
        .clk         (clk),
        .rstn        (rstn),
        .instr_valid (instr_valid),
        .instr       (instr),
        .f_valid     (f_valid),
        .f_pc        (f_pc),
        .f_instr     (f_instr)
    );

    decoder decoder_i (
        .f_instr   (f_instr),
        .rs1       (rs1),
        .rs2       (rs2),
        .rd        (rd),
        .imm       (imm),
        .use_imm   (use_imm),
        .alu_op    (alu_op),
        .writes_rd (writes_rd)
    );

    // written straight from the completion register.
    register_file register_file_i (
        .clk      (clk),
        .rstn     (rstn),
        .rs1      (rs1),
        .rs2      (rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wr_en    (retire_write),
        .wr_addr  (retire_rd),
        .wr_data  (retire_data)
    );

    dispatch_stage dispatch_stage_i (
        .clk          (clk),
        .rstn         (rstn),
        .f_valid      (f_valid),
        .f_pc         (f_pc),
        .rs1          (rs1),
        .rs2          (rs2),
        .rd           (rd),
        .imm          (imm),
        .use_imm      (use_imm),
        .alu_op       (alu_op),
        .writes_rd    (writes_rd),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .alu_result   (alu_result),
        .retire_valid (retire_valid),
        .retire_write (retire_write),
        .retire_rd    (retire_rd),
        .retire_data  (retire_data),
        .d_valid      (d_valid),
        .d_pc         (d_pc),
        .d_rd         (d_rd),
        .d_write      (d_write),
        .d_alu_op     (d_alu_op),
        .d_a          (d_a),
        .d_b          (d_b)
    );

    alu alu_i (
        .d_a        (d_a),
        .d_b        (d_b),
        .d_alu_op   (d_alu_op),
        .alu_result (alu_result)
    );

    complete_stage complete_stage_i (
        .clk          (clk),
        .rstn         (rstn),
        .d_valid      (d_valid),
        .d_pc         (d_pc),
        .d_rd         (d_rd),
        .d_write      (d_write),
        .alu_result   (alu_result),
        .retire_valid (retire_valid),
        .retire_pc    (retire_pc),
        .retire_write (retire_write),
        .retire_rd    (retire_rd),
        .retire_data  (retire_data)
    );

endmodule

`default_nettype wire

//--- test/tb_cpu_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cpu_core;

    localparam cpu_pkg::word_t RESET_PC = 32'h0000_1000;
    localparam int NUM_RANDOM = 400;
    localparam int DRAIN_LIMIT = 64;

    logic               clk;
    logic               rstn;
    logic               instr_valid;
    cpu_pkg::word_t     instr;
    logic               retire_valid;
    cpu_pkg::word_t     retire_pc;
    logic               retire_write;
    cpu_pkg::reg_addr_t retire_rd;
    cpu_pkg::word_t     retire_data;

    // architectural registers of the reference model.
    logic [31:0] arch_regs [0:31];
    logic [31:0] lfsr;

    // expected retire fields, one entry per sent instruction.
    logic [31:0] exp_pc [$];
    logic        exp_wr [$];
    logic [4:0]  exp_rd [$];
    logic [31:0] exp_data [$];

    int sent = 0;
    int retired = 0;
    int edge_cnt = 0;
    int first_edge = -1;

    cpu_core #(
        .RESET_PC (RESET_PC)
    ) cpu_core_i (
        .clk          (clk),
        .rstn         (rstn),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .retire_valid (retire_valid),
        .retire_pc    (retire_pc),
        .retire_write (retire_write),
        .retire_rd    (retire_rd),
        .retire_data  (retire_data)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        edge_cnt <= edge_cnt + 1;
    end

    task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("error at %0t: %s is %h, expected %h", $time, what, got, exp);
            $display("CHECKS FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    // galois form, taps 32 22 2 1.
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    // executes one instruction on the architectural state.
    function automatic logic [31:0] model_exec(input logic [31:0] ins, output logic wr,
                                               output logic [4:0] rd);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic        ok;
        a = arch_regs[ins[19:15]];
        b = {{20{ins[31]}}, ins[31:20]};
        res = '0;
        ok = 1'b1;
        rd = ins[11:7];
        if (ins[6:0] == 7'b0110011) begin
            b = arch_regs[ins[24:20]];
        end
        case (ins[6:0])
            7'b0110011, 7'b0010011: begin
                case (ins[14:12])
                    // bit 5 of the opcode marks the register form, the only one with sub.
                    3'b000:  res = (ins[30] && ins[5]) ? a - b : a + b;
                    3'b001:  res = a << b[4:0];
                    3'b010:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    3'b011:  res = (a < b) ? 32'd1 : 32'd0;
                    3'b100:  res = a ^ b;
                    3'b101:  res = ins[30] ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
                    3'b110:  res = a | b;
                    default: res = a & b;
                endcase
            end
            7'b0110111: res = {ins[31:12], 12'b0};
            default:    ok = 1'b0;
        endcase
        wr = ok && (rd != 5'd0);
        if (wr) begin
            arch_regs[rd] = res;
        end
        return res;
    endfunction

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, 7'b0110111};
    endfunction

    task automatic send(input logic [31:0] ins);
        logic        wr;
        logic [4:0]  rd;
        logic [31:0] data;
        @(posedge clk);
        instr_valid <= 1'b1;
        instr       <= ins;
        data = model_exec(ins, wr, rd);
        exp_pc.push_back(RESET_PC + 32'(4 * sent));
        exp_wr.push_back(wr);
        exp_rd.push_back(rd);
        exp_data.push_back(data);
        sent++;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            instr_valid <= 1'b0;
        end
    endtask

    // registers limited to x0..x7 so that dependencies are frequent.
    task automatic random_instr(output logic [31:0] ins);
        logic [31:0] cls;
        logic [31:0] rd;
        logic [31:0] rs1;
        logic [31:0] rs2;
        logic [31:0] f3;
        logic [31:0] alt;
        logic [31:0] imm;
        logic [31:0] sel;
        logic [6:0]  major;
        take_bits(3, cls);
        take_bits(3, rd);
        take_bits(3, rs1);
        take_bits(3, rs2);
        take_bits(3, f3);
        take_bits(1, alt);
        if (cls < 3) begin
            // alt bit only for add/sub and srl/sra.
            if (f3[2:0] != 3'b000 && f3[2:0] != 3'b101) begin
                alt = '0;
            end
            ins = r_type({1'b0, alt[0], 5'b0}, rs2[4:0], rs1[4:0], f3[2:0], rd[4:0]);
        end else if (cls < 6) begin
            take_bits(12, imm);
            if (f3[2:0] == 3'b001) begin
                imm = {20'b0, 7'b0, imm[4:0]};
            end else if (f3[2:0] == 3'b101) begin
                imm = {20'b0, 1'b0, alt[0], 5'b0, imm[4:0]};
            end
            ins = i_type(imm[11:0], rs1[4:0], f3[2:0], rd[4:0]);
        end else if (cls == 6) begin
            take_bits(20, imm);
            ins = u_type(imm[19:0], rd[4:0]);
        end else begin
            // load, store, branch or auipc.
            take_bits(2, sel);
            take_bits(25, imm);
            case (sel[1:0])
                2'd0:    major = 7'b0000011;
                2'd1:    major = 7'b0100011;
                2'd2:    major = 7'b1100011;
                default: major = 7'b0010111;
            endcase
            ins = {imm[24:0], major};
        end
    endtask

    // outputs are sampled on the falling edge.
    always @(negedge clk) begin
        if (!rstn) begin
            check("retire_valid during reset", {31'b0, retire_valid}, 32'd0);
        end
        if (instr_valid && first_edge < 0) begin
            first_edge = edge_cnt;
        end
        if (retire_valid) begin
            if (retired >= exp_pc.size()) begin
                $display("retire strobe seen with no instruction in flight at %0t", $time);
                $display("CHECKS FAILED");
                $fatal(1, "unexpected retire");
            end else begin
                if (retired == 0) begin
                    check("first retire latency", 32'(edge_cnt - first_edge), 32'd3);
                end
                check("retire_pc", retire_pc, exp_pc[retired]);
                check("retire_write", {31'b0, retire_write}, {31'b0, exp_wr[retired]});
                check("retire_rd", {27'b0, retire_rd}, {27'b0, exp_rd[retired]});
                if (exp_wr[retired]) begin
                    check("retire_data", retire_data, exp_data[retired]);
                end
                retired++;
            end
        end
    end

    initial begin
        logic [31:0] ins;
        logic [31:0] gap;
        int          waited;
        clk = 1'b0;
        rstn <= 1'b0;
        instr_valid <= 1'b0;
        instr <= '0;
        lfsr = 32'hb27b_22db;
        for (int i = 0; i < 32; i++) begin
            arch_regs[i] = '0;
        end
        repeat (8) @(posedge clk);
        rstn <= 1'b1;
        idle(2);
        // negative lui, sign-extended addi, srai, sub, compares, shift by a register.
        send(u_type(20'h8_1234, 5'd1));
        send(i_type(12'hff6, 5'd1, 3'b000, 5'd2));
        send(i_type({7'b0100000, 5'd4}, 5'd1, 3'b101, 5'd3));
        send(r_type(7'b0100000, 5'd2, 5'd1, 3'b000, 5'd4));
        send(r_type(7'b0, 5'd2, 5'd3, 3'b010, 5'd5));
        send(r_type(7'b0, 5'd2, 5'd3, 3'b011, 5'd6));
        send(r_type(7'b0, 5'd4, 5'd1, 3'b001, 5'd7));
        // writes to x0 and an ecall, then x0 read back.
        send(i_type(12'h005, 5'd0, 3'b000, 5'd0));
        send(32'h0000_0073);
        send(r_type(7'b0, 5'd0, 5'd0, 3'b000, 5'd1));
        idle(3);
        for (int i = 0; i < NUM_RANDOM; i++) begin
            random_instr(ins);
            send(ins);
            take_bits(2, gap);
            if (gap == 3) begin
                take_bits(3, gap);
                idle(int'(gap));
            end
        end
        idle(1);
        waited = 0;
        while (retired < sent) begin
            @(posedge clk);
            waited++;
            if (waited > DRAIN_LIMIT) begin
                $display("timed out waiting for the pipeline to drain");
                $display("CHECKS FAILED");
                $fatal(1, "drain timeout");
            end
        end
        // extra retires in these cycles fail in the compare process.
        idle(4);
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- sim.f
source/cpu_pkg.sv
source/fetch_stage.sv
source/decoder.sv
source/register_file.sv
source/dispatch_stage.sv
source/alu.sv
source/complete_stage.sv
source/cpu_core.sv
test/tb_cpu_core.sv

//--- run.sh
#!/bin/sh
# build and run the cpu_core testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f sim.f --top-module tb_cpu_core -o tb_cpu_core
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_cpu_core > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^ALL CHECKS PASSED$" sim.log; then
    echo "simulation passed"
    exit 0
fi
echo "simulation failed"
exit 1
